// File: Makefile
VERILATOR  ?= verilator
TOP        := pat_core_tb
FILELIST   := pat_core.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/pat_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_cfg.svh"

module pat_core_tb;
	import pat_isa_pkg::*;
	import pat_pipe_pkg::*;

	// one row per instruction slot
	typedef struct packed {
		instr_t                 instr;
		in_ports_t              ports;   // port values driven with this slot
		logic                   chk;     // compare o_out once this row has committed
		logic [`PAT_DATA_W-1:0] exp;
	} row_t;

	localparam logic [`PAT_INSTR_W-1:0] nop = `PAT_INSTR_NOP;

	logic                   clk;
	logic                   reset;
	instr_t                 i_instr;
	in_ports_t              i_in;
	logic [`PAT_DATA_W-1:0] o_out;

	row_t      rows[$];
	string     names[$];
	in_ports_t cur_ports;    // recorded with every new row
	int        passes = 0;
	int        fails  = 0;
	int        cycles = 0;
	int        limit  = 0;   // watchdog limit in cycles

	pat_core i_dut (.clk(clk), .reset(reset), .i_instr(i_instr), .i_in(i_in),
		.o_out(o_out));

	// ==================================================
	// instruction encoders
	function automatic logic [`PAT_INSTR_W-1:0] i8_word(logic [`PAT_REG_ADR_W-1:0] rn,
		logic [`PAT_OP_W-1:0] op, logic [`PAT_DATA_W-1:0] imm);
		return {rn, 6'b0, COND_AL, op, imm};   // reserved bits stay zero
	endfunction

	// i3 opcode in the upper nibble, 3-bit field at the bottom
	function automatic logic [`PAT_INSTR_W-1:0] i3_word(logic [`PAT_REG_ADR_W-1:0] rn,
		logic [`PAT_OP_W-1:0] op, logic [2:0] low);
		return i8_word(rn, OP8_PREFIX3, {op, 1'b0, low});
	endfunction

	function automatic logic [`PAT_INSTR_W-1:0] i0_word(logic [`PAT_REG_ADR_W-1:0] rn,
		logic [`PAT_OP_W-1:0] op);
		return i8_word(rn, OP8_PREFIX3, {OP3_PREFIX0, op});
	endfunction

	function automatic logic [`PAT_INSTR_W-1:0] out_word(logic [`PAT_REG_ADR_W-1:0] rn);
		return i3_word(rn, OP3_OUT, 3'd0);
	endfunction

	function automatic logic [`PAT_INSTR_W-1:0] with_cond(logic [1:0] c,
		logic [`PAT_INSTR_W-1:0] w);
		logic [`PAT_INSTR_W-1:0] r;
		r = w;
		r[`PAT_OP_W+`PAT_DATA_W +: 2] = c;   // cond sits just above op8
		return r;
	endfunction

	task automatic add_row(input string name, input logic [`PAT_INSTR_W-1:0] w,
		input logic chk, input logic [`PAT_DATA_W-1:0] exp);
		row_t r;
		r.instr = instr_t'(w);
		r.ports = cur_ports;
		r.chk   = chk;
		r.exp   = exp;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic check_out(input int k);
		assert (o_out === rows[k].exp)
		begin
			passes++;
			$display("ok    %s o_out %h", names[k], o_out);
		end
		else
		begin
			fails++;
			$display("error %s: expected %h, actual %h", names[k], rows[k].exp, o_out);
		end
	endtask

	// ==================================================
	// program, readers kept two slots behind writers
	task automatic build_table();
		cur_ports = '{port0: 8'h11, port1: 8'h22, port2: 8'h33};
		add_row("reset_out", nop, 1'b1, 8'h00);   // o_out cleared by reset
		add_row("ldi", i8_word(3'd1, OP8_LDI, 8'h5a), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("ldi_out", out_word(3'd1), 1'b1, 8'h5a);
		// logic and arithmetic, R1 immediate chain and R2 op R3
		add_row("ldi", i8_word(3'd2, OP8_LDI, 8'hf0), 1'b0, 8'h00);
		add_row("ldi", i8_word(3'd3, OP8_LDI, 8'h0f), 1'b0, 8'h00);
		add_row("ori", i8_word(3'd1, OP8_ORI, 8'h03), 1'b0, 8'h00);
		add_row("orr", i8_word(3'd2, OP8_ORR, 8'h03), 1'b0, 8'h00);
		add_row("ori", out_word(3'd1), 1'b1, 8'h5b);
		add_row("orr", out_word(3'd2), 1'b1, 8'hff);
		add_row("andi", i8_word(3'd1, OP8_ANDI, 8'h0f), 1'b0, 8'h00);
		add_row("andr", i8_word(3'd2, OP8_ANDR, 8'h03), 1'b0, 8'h00);
		add_row("andi", out_word(3'd1), 1'b1, 8'h0b);
		add_row("andr", out_word(3'd2), 1'b1, 8'h0f);
		add_row("addi_wrap", i8_word(3'd1, OP8_ADDI, 8'hfa), 1'b0, 8'h00);   // 0x105
		add_row("addr", i8_word(3'd2, OP8_ADDR, 8'h03), 1'b0, 8'h00);
		add_row("addi_wrap", out_word(3'd1), 1'b1, 8'h05);
		add_row("addr", out_word(3'd2), 1'b1, 8'h1e);
		add_row("subi", i8_word(3'd1, OP8_SUBI, 8'h07), 1'b0, 8'h00);   // borrow
		add_row("subr", i8_word(3'd2, OP8_SUBR, 8'h03), 1'b0, 8'h00);
		add_row("subi", out_word(3'd1), 1'b1, 8'hfe);
		add_row("subr", out_word(3'd2), 1'b1, 8'h0f);
		add_row("not", i0_word(3'd1, OP0_NOT), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("not", out_word(3'd1), 1'b1, 8'h01);
		// shifts, amount is field + 1, register amounts in R5 (2) and R6 (4)
		add_row("ldi", i8_word(3'd4, OP8_LDI, 8'h96), 1'b0, 8'h00);
		add_row("ldi", i8_word(3'd5, OP8_LDI, 8'h01), 1'b0, 8'h00);
		add_row("shlz_i1", i3_word(3'd4, OP3_SHLZI, 3'd0), 1'b0, 8'h00);
		add_row("ldi", i8_word(3'd6, OP8_LDI, 8'h03), 1'b0, 8'h00);
		add_row("shlz_i1", out_word(3'd4), 1'b1, 8'h2c);
		add_row("shlo_r2", i3_word(3'd4, OP3_SHLOR, 3'd5), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("shlo_r2", out_word(3'd4), 1'b1, 8'hb3);
		add_row("shrz_r4", i3_word(3'd4, OP3_SHRZR, 3'd6), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("shrz_r4", out_word(3'd4), 1'b1, 8'h0b);
		add_row("shro_i3", i3_word(3'd4, OP3_SHROI, 3'd2), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("shro_i3", out_word(3'd4), 1'b1, 8'he1);
		add_row("shlz_r2", i3_word(3'd4, OP3_SHLZR, 3'd5), 1'b0, 8'h00);
		add_row("ldi", i8_word(3'd7, OP8_LDI, 8'h3c), 1'b0, 8'h00);
		add_row("shlz_r2", out_word(3'd4), 1'b1, 8'h84);
		add_row("shlo_i4", i3_word(3'd7, OP3_SHLOI, 3'd3), 1'b0, 8'h00);
		add_row("shrz_i2", i3_word(3'd4, OP3_SHRZI, 3'd1), 1'b0, 8'h00);
		add_row("shlo_i4", out_word(3'd7), 1'b1, 8'hcf);
		add_row("shrz_i2", out_word(3'd4), 1'b1, 8'h21);
		add_row("shro_r4", i3_word(3'd7, OP3_SHROR, 3'd6), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("shro_r4", out_word(3'd7), 1'b1, 8'hfc);
		// ==================================================
		// input ports, read in the slot after the IN itself
		cur_ports = '{port0: 8'ha1, port1: 8'hb2, port2: 8'hc3};
		add_row("in_port0", i3_word(3'd1, OP3_IN, 3'b001), 1'b0, 8'h00);
		add_row("in_port1", i3_word(3'd2, OP3_IN, 3'b010), 1'b0, 8'h00);
		add_row("in_port2", i3_word(3'd3, OP3_IN, 3'b100), 1'b0, 8'h00);
		add_row("in_bad_sel", i3_word(3'd5, OP3_IN, 3'b011), 1'b0, 8'h00);
		add_row("in_port0", out_word(3'd1), 1'b1, 8'ha1);
		add_row("in_port1", out_word(3'd2), 1'b1, 8'hb2);
		add_row("in_port2", out_word(3'd3), 1'b1, 8'hc3);
		add_row("in_bad_sel", out_word(3'd5), 1'b1, 8'ha1);
		cur_ports = '{port0: 8'h11, port1: 8'h22, port2: 8'h33};
		// conditions, flags from TEST on zero, negative, positive
		add_row("ldi", i8_word(3'd6, OP8_LDI, 8'h00), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("test_zero", i0_word(3'd6, OP0_TEST), 1'b0, 8'h00);   // z=1 n=0
		add_row("cond_z_take", with_cond(COND_Z, i8_word(3'd1, OP8_LDI, 8'h11)), 1'b0, 8'h00);
		add_row("cond_nz_skip", with_cond(COND_NZ, i8_word(3'd2, OP8_LDI, 8'h22)), 1'b0, 8'h00);
		add_row("cond_n_skip", with_cond(COND_N, out_word(3'd3)), 1'b1, 8'ha1);
		add_row("cond_z_take", out_word(3'd1), 1'b1, 8'h11);
		add_row("cond_nz_skip", out_word(3'd2), 1'b1, 8'hb2);
		add_row("test_neg", i0_word(3'd7, OP0_TEST), 1'b0, 8'h00);   // z=0 n=1
		add_row("cond_n_take", with_cond(COND_N, out_word(3'd3)), 1'b1, 8'hc3);
		add_row("cond_z_skip", with_cond(COND_Z, out_word(3'd1)), 1'b1, 8'hc3);
		add_row("ldi", i8_word(3'd4, OP8_LDI, 8'h40), 1'b0, 8'h00);
		add_row("gap", nop, 1'b0, 8'h00);
		add_row("test_pos", i0_word(3'd4, OP0_TEST), 1'b0, 8'h00);   // z=0 n=0
		add_row("cond_pos_n_skip", with_cond(COND_N, out_word(3'd7)), 1'b1, 8'hc3);
		add_row("cond_nz_take", with_cond(COND_NZ, out_word(3'd4)), 1'b1, 8'h40);
		// idle slots aimed at R1
		add_row("nop_idle", i0_word(3'd1, OP0_NOP), 1'b0, 8'h00);
		add_row("unknown_i0", i0_word(3'd1, 4'b1001), 1'b0, 8'h00);
		add_row("unknown_i8", i8_word(3'd1, 4'b1010, 8'hff), 1'b1, 8'h40);   // o_out held
		add_row("nop_keeps_reg", out_word(3'd1), 1'b1, 8'h11);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns
	end

	// watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		build_table();
		limit   = rows.size() + 2 + 10;   // table + reset + margin
		reset   = 1'b1;
		i_instr = instr_t'(nop);
		i_in    = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// row t is sampled one edge later and commits two edges after that
		for (int t = 0; t < rows.size() + 3; t++)
		begin
			@(posedge clk);
			if (t < rows.size())
			begin
				i_instr <= rows[t].instr;
				i_in    <= rows[t].ports;
			end
			else
				i_instr <= instr_t'(nop);   // drain
			@(negedge clk);
			if (t >= 3 && rows[t-3].chk)
				check_out(t - 3);
		end
		$display("checks: %0d passed, %0d failed", passes, fails);
		if (fails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/pat_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_cfg.svh"

module pat_alu
(
	input  wire pat_pipe_pkg::alu_op_e  i_op,
	input  wire logic [`PAT_DATA_W-1:0] i_a,
	input  wire logic [`PAT_DATA_W-1:0] i_b,
	output logic [`PAT_DATA_W-1:0]      o_y
);
	import pat_pipe_pkg::*;

	localparam logic [`PAT_DATA_W-1:0] ones = '1;

	logic [`PAT_SHAMT_W:0]  sh_n;    // shift distance 1..4
	logic [`PAT_DATA_W-1:0] shlz;
	logic [`PAT_DATA_W-1:0] shlo;
	logic [`PAT_DATA_W-1:0] shrz;
	logic [`PAT_DATA_W-1:0] shro;

	// ==================================================
	// shifter
	// only b[1:0] is looked at, so every amount is legal
	assign sh_n = {1'b0, i_b[`PAT_SHAMT_W-1:0]} + 1'b1;
	assign shlz = i_a << sh_n;
	assign shrz = i_a >> sh_n;
	assign shlo = shlz | ~(ones << sh_n);   // ones shifted into the low end
	assign shro = shrz | ~(ones >> sh_n);   // ones shifted into the high end

	// ==================================================
	// result select
	always_comb
	begin
		case (i_op)
			ALU_PASS_B: o_y = i_b;
			ALU_OR:     o_y = i_a | i_b;
			ALU_AND:    o_y = i_a & i_b;
			ALU_ADD:    o_y = i_a + i_b;   // wraps mod 256
			ALU_SUB:    o_y = i_a - i_b;
			ALU_NOT:    o_y = ~i_a;
			ALU_SHLZ:   o_y = shlz;
			ALU_SHLO:   o_y = shlo;
			ALU_SHRZ:   o_y = shrz;
			ALU_SHRO:   o_y = shro;
			default:    o_y = i_b;
		endcase
	end

endmodule

`default_nettype wire

// File: design/pat_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_cfg.svh"

module pat_core
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire pat_isa_pkg::instr_t     i_instr,
	input  wire pat_pipe_pkg::in_ports_t i_in,
	output logic [`PAT_DATA_W-1:0]       o_out
);
	import pat_pipe_pkg::*;

	logic [`PAT_REG_ADR_W-1:0] rn_adr;
	logic [`PAT_REG_ADR_W-1:0] rs_adr;
	logic [`PAT_DATA_W-1:0]    rn_data;
	logic [`PAT_DATA_W-1:0]    rs_data;
	ctrl_t                     ctrl;      // decode register
	logic [`PAT_DATA_W-1:0]    dec_a;
	logic [`PAT_DATA_W-1:0]    dec_b;
	alu_op_e                   alu_op;
	logic [`PAT_DATA_W-1:0]    alu_a;
	logic [`PAT_DATA_W-1:0]    alu_b;
	logic [`PAT_DATA_W-1:0]    alu_y;
	logic                      wr_en;     // commit write-back
	logic [`PAT_REG_ADR_W-1:0] wr_adr;
	logic [`PAT_DATA_W-1:0]    wr_data;

	pat_decode u_decode (.clk(clk), .reset(reset), .i_instr(i_instr), .i_in(i_in),
		.o_rn_adr(rn_adr), .o_rs_adr(rs_adr), .i_rn_data(rn_data), .i_rs_data(rs_data),
		.o_ctrl(ctrl), .o_a(dec_a), .o_b(dec_b));

	pat_regfile u_regfile (.clk(clk), .i_rd_adr_a(rn_adr), .i_rd_adr_b(rs_adr),
		.o_rd_data_a(rn_data), .o_rd_data_b(rs_data),
		.i_wr_en(wr_en), .i_wr_adr(wr_adr), .i_wr_data(wr_data));

	pat_execute u_execute (.clk(clk), .reset(reset), .i_ctrl(ctrl), .i_a(dec_a), .i_b(dec_b),
		.o_alu_op(alu_op), .o_alu_a(alu_a), .o_alu_b(alu_b), .i_alu_y(alu_y),
		.o_wr_en(wr_en), .o_wr_adr(wr_adr), .o_wr_data(wr_data), .o_out(o_out));

	pat_alu u_alu (.i_op(alu_op), .i_a(alu_a), .i_b(alu_b), .o_y(alu_y));

endmodule

`default_nettype wire

// File: design/pat_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_cfg.svh"

module pat_decode
(
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire pat_isa_pkg::instr_t       i_instr,
	input  wire pat_pipe_pkg::in_ports_t   i_in,
	output logic [`PAT_REG_ADR_W-1:0]      o_rn_adr,
	output logic [`PAT_REG_ADR_W-1:0]      o_rs_adr,
	input  wire logic [`PAT_DATA_W-1:0]    i_rn_data,
	input  wire logic [`PAT_DATA_W-1:0]    i_rs_data,
	output pat_pipe_pkg::ctrl_t            o_ctrl,
	output logic [`PAT_DATA_W-1:0]         o_a,
	output logic [`PAT_DATA_W-1:0]         o_b
);
	import pat_isa_pkg::*;
	import pat_pipe_pkg::*;

	localparam ctrl_t ctrl_nop = '{
		alu_op:  ALU_PASS_B,
		cond:    COND_AL,
		rd:      '0,
		wr_reg:  1'b0,
		do_out:  1'b0,
		do_test: 1'b0
	};

	instr_t                   instr_q;   // instruction register
	op3_e                     op3;
	op0_e                     op0;
	logic                     is_i8;
	logic                     is_i3;
	logic [`PAT_IN_PORTS-1:0] in_sel;    // one-hot port select
	logic [`PAT_DATA_W-1:0]   in_word;
	ctrl_t                    ctrl_d;
	logic [`PAT_DATA_W-1:0]   a_d;
	logic [`PAT_DATA_W-1:0]   b_d;

	// ==================================================
	// opcode spaces, nested behind all-ones prefixes
	assign op3    = op3_e'(instr_q.imm8[7:4]);
	assign op0    = op0_e'(instr_q.imm8[3:0]);
	assign is_i8  = (instr_q.op8 != OP8_PREFIX3);
	assign is_i3  = !is_i8 && (op3 != OP3_PREFIX0);
	assign in_sel = instr_q.imm8[`PAT_IN_PORTS-1:0];

	assign o_rn_adr = instr_q.rn;
	assign o_rs_adr = instr_q.imm8[`PAT_REG_ADR_W-1:0];   // register-form source

	always_comb
	begin
		case (in_sel)
			3'b001:  in_word = i_in.port0;
			3'b010:  in_word = i_in.port1;
			3'b100:  in_word = i_in.port2;
			default: in_word = i_in.port0;   // bad select falls back to port0
		endcase
	end

	// ==================================================
	// control and operand selection
	always_comb
	begin
		ctrl_d.alu_op  = ALU_PASS_B;
		ctrl_d.cond    = instr_q.cond;
		ctrl_d.rd      = instr_q.rn;
		ctrl_d.wr_reg  = 1'b0;
		ctrl_d.do_out  = 1'b0;
		ctrl_d.do_test = 1'b0;
		a_d            = i_rn_data;   // R[rn]
		b_d            = i_rs_data;   // R[imm8[2:0]]
		if (is_i8)
		begin
			if (!instr_q.op8[0])
				b_d = instr_q.imm8;   // even i8 opcodes are immediate forms
			ctrl_d.wr_reg = 1'b1;
			case (instr_q.op8)
				OP8_ORI, OP8_ORR:   ctrl_d.alu_op = ALU_OR;
				OP8_ANDI, OP8_ANDR: ctrl_d.alu_op = ALU_AND;
				OP8_ADDI, OP8_ADDR: ctrl_d.alu_op = ALU_ADD;
				OP8_SUBI, OP8_SUBR: ctrl_d.alu_op = ALU_SUB;
				OP8_LDI:
				begin
					ctrl_d.alu_op = ALU_OR;   // 0 | imm8
					a_d           = '0;
				end
				default: ctrl_d.wr_reg = 1'b0;   // unknown, behaves as nop
			endcase
		end
		else if (is_i3)
		begin
			if (!op3[3] && !op3[0])   // shift immediates use the 3-bit field
				b_d = `PAT_DATA_W'(instr_q.imm8[2:0]);
			case (op3)
				OP3_SHLZI, OP3_SHLZR: ctrl_d.alu_op = ALU_SHLZ;
				OP3_SHLOI, OP3_SHLOR: ctrl_d.alu_op = ALU_SHLO;
				OP3_SHRZI, OP3_SHRZR: ctrl_d.alu_op = ALU_SHRZ;
				OP3_SHROI, OP3_SHROR: ctrl_d.alu_op = ALU_SHRO;
				OP3_IN:
				begin
					ctrl_d.alu_op = ALU_OR;   // port | 0
					a_d           = in_word;
					b_d           = '0;
				end
				OP3_OUT: ctrl_d.do_out = 1'b1;
				default: ;
			endcase
			ctrl_d.wr_reg = !op3[3] || (op3 == OP3_IN);   // shifts and in write back
		end
		else
		begin
			// i0 space
			case (op0)
				OP0_NOT:
				begin
					ctrl_d.alu_op = ALU_NOT;
					ctrl_d.wr_reg = 1'b1;
				end
				OP0_TEST: ctrl_d.do_test = 1'b1;
				OP0_NOP:  ;
				default:  ;   // unknown i0 opcodes idle too
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q <= instr_t'(`PAT_INSTR_NOP);
			o_ctrl  <= ctrl_nop;
		end
		else
		begin
			instr_q <= i_instr;
			o_ctrl  <= ctrl_d;
		end
	end

	always_ff @(posedge clk)
	begin
		o_a <= a_d;
		o_b <= b_d;
	end

	// execute relies on a legal operation in every slot
	a_alu_op_known: assert property (@(posedge clk) disable iff (reset)
		o_ctrl.alu_op inside {ALU_PASS_B, ALU_OR, ALU_AND, ALU_ADD, ALU_SUB,
			ALU_NOT, ALU_SHLZ, ALU_SHLO, ALU_SHRZ, ALU_SHRO});

endmodule

`default_nettype wire

// File: design/pat_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_cfg.svh"

module pat_execute
(
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire pat_pipe_pkg::ctrl_t       i_ctrl,
	input  wire logic [`PAT_DATA_W-1:0]    i_a,
	input  wire logic [`PAT_DATA_W-1:0]    i_b,
	output pat_pipe_pkg::alu_op_e          o_alu_op,
	output logic [`PAT_DATA_W-1:0]         o_alu_a,
	output logic [`PAT_DATA_W-1:0]         o_alu_b,
	input  wire logic [`PAT_DATA_W-1:0]    i_alu_y,
	output logic                           o_wr_en,
	output logic [`PAT_REG_ADR_W-1:0]      o_wr_adr,
	output logic [`PAT_DATA_W-1:0]         o_wr_data,
	output logic [`PAT_DATA_W-1:0]         o_out
);
	import pat_isa_pkg::*;

	logic z_q;        // zero flag, set by test
	logic n_q;        // negative flag
	logic cond_ok;    // commit enable for this slot

	// ==================================================
	// condition check on the flags as they stand now
	always_comb
	begin
		case (i_ctrl.cond)
			COND_Z:  cond_ok = z_q;
			COND_NZ: cond_ok = !z_q;
			COND_N:  cond_ok = n_q;
			default: cond_ok = 1'b1;   // always
		endcase
	end

	// alu sees the registered operands directly
	assign o_alu_op = i_ctrl.alu_op;
	assign o_alu_a  = i_a;
	assign o_alu_b  = i_b;

	// write-back lands on the same edge as o_out and the flags
	assign o_wr_en   = cond_ok && i_ctrl.wr_reg;
	assign o_wr_adr  = i_ctrl.rd;
	assign o_wr_data = i_alu_y;

	// ==================================================
	// output port and flags
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_out <= '0;
			z_q   <= 1'b0;
			n_q   <= 1'b0;
		end
		else
		begin
			if (cond_ok && i_ctrl.do_out)
				o_out <= i_a;   // R[rn]
			if (cond_ok && i_ctrl.do_test)
			begin
				z_q <= (i_a == '0);
				n_q <= i_a[`PAT_DATA_W-1];
			end
		end
	end

	// decode must hand over at most one commit kind per slot
	a_one_commit: assert property (@(posedge clk) disable iff (reset)
		$onehot0({i_ctrl.wr_reg, i_ctrl.do_out, i_ctrl.do_test}));

endmodule

`default_nettype wire

// File: design/pat_isa_pkg.sv
`default_nettype none

`include "pat_cfg.svh"

package pat_isa_pkg;

	// i8 opcode space, all ones opens the i3 space
	typedef enum logic [`PAT_OP_W-1:0] {
		OP8_ORI     = 4'b0000,
		OP8_ORR     = 4'b0001,
		OP8_ANDI    = 4'b0010,
		OP8_ANDR    = 4'b0011,
		OP8_ADDI    = 4'b0100,
		OP8_ADDR    = 4'b0101,
		OP8_SUBI    = 4'b0110,
		OP8_SUBR    = 4'b0111,
		OP8_LDI     = 4'b1000,
		OP8_PREFIX3 = 4'b1111
	} op8_e;

	// i3 opcodes live in imm8[7:4]
	typedef enum logic [`PAT_OP_W-1:0] {
		OP3_SHLZI   = 4'b0000,
		OP3_SHLZR   = 4'b0001,
		OP3_SHLOI   = 4'b0010,
		OP3_SHLOR   = 4'b0011,
		OP3_SHRZI   = 4'b0100,
		OP3_SHRZR   = 4'b0101,
		OP3_SHROI   = 4'b0110,      // right shift, ones fill
		OP3_SHROR   = 4'b0111,
		OP3_IN      = 4'b1000,
		OP3_OUT     = 4'b1011,
		OP3_PREFIX0 = 4'b1111       // opens the i0 space
	} op3_e;

	// i0 opcodes live in imm8[3:0]
	typedef enum logic [`PAT_OP_W-1:0] {
		OP0_NOT  = 4'b0000,
		OP0_TEST = 4'b0010,
		OP0_NOP  = 4'b0101
	} op0_e;

	typedef enum logic [1:0] {
		COND_Z  = 2'd0,   // zero flag set
		COND_NZ = 2'd1,   // zero flag clear
		COND_N  = 2'd2,   // negative flag set
		COND_AL = 2'd3    // always
	} cond_e;

	typedef struct packed {
		logic [`PAT_REG_ADR_W-1:0] rn;   // destination, also operand a source
		// leftover field pointer and field flag bits, ignored by the core
		logic [`PAT_INSTR_W-`PAT_REG_ADR_W-2-`PAT_OP_W-`PAT_DATA_W-1:0] reserved;
		cond_e                     cond;
		op8_e                      op8;
		logic [`PAT_DATA_W-1:0]    imm8; // also carries i3 / i0 opcode
	} instr_t;

endpackage

`default_nettype wire

// File: design/pat_pipe_pkg.sv
`default_nettype none

`include "pat_cfg.svh"

package pat_pipe_pkg;

	typedef enum logic [3:0] {
		ALU_PASS_B = 4'd0,
		ALU_OR     = 4'd1,
		ALU_AND    = 4'd2,
		ALU_ADD    = 4'd3,
		ALU_SUB    = 4'd4,
		ALU_NOT    = 4'd5,   // ~a
		ALU_SHLZ   = 4'd6,
		ALU_SHLO   = 4'd7,
		ALU_SHRZ   = 4'd8,
		ALU_SHRO   = 4'd9
	} alu_op_e;

	// ===============================================
	// decoded controls, decode -> execute
	typedef struct packed {
		alu_op_e                   alu_op;
		pat_isa_pkg::cond_e        cond;      // tested at commit
		logic [`PAT_REG_ADR_W-1:0] rd;        // write-back address
		logic                      wr_reg;    // result goes to R[rd]
		logic                      do_out;    // R[rn] goes to o_out
		logic                      do_test;   // flags from R[rn]
	} ctrl_t;

	typedef struct packed {
		logic [`PAT_DATA_W-1:0] port0;
		logic [`PAT_DATA_W-1:0] port1;
		logic [`PAT_DATA_W-1:0] port2;
	} in_ports_t;

endpackage

`default_nettype wire

// File: design/pat_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_cfg.svh"

module pat_regfile
(
	input  wire logic                     clk,
	input  wire logic [`PAT_REG_ADR_W-1:0] i_rd_adr_a,
	input  wire logic [`PAT_REG_ADR_W-1:0] i_rd_adr_b,
	output logic [`PAT_DATA_W-1:0]         o_rd_data_a,
	output logic [`PAT_DATA_W-1:0]         o_rd_data_b,
	input  wire logic                      i_wr_en,
	input  wire logic [`PAT_REG_ADR_W-1:0] i_wr_adr,
	input  wire logic [`PAT_DATA_W-1:0]    i_wr_data
);
	logic [`PAT_DATA_W-1:0] regs [`PAT_REG_COUNT];

	assign o_rd_data_a = regs[i_rd_adr_a];   // async read, sees the new value after the edge
	assign o_rd_data_b = regs[i_rd_adr_b];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			regs[i_wr_adr] <= i_wr_data;
	end

	// commit address comes from the decode register two stages back
	a_wr_adr_known: assert property (@(posedge clk) i_wr_en |-> !$isunknown(i_wr_adr));

endmodule

`default_nettype wire

// File: include/pat_cfg.svh
`ifndef PAT_CFG_SVH
`define PAT_CFG_SVH

// datapath and instruction sizes
`define PAT_DATA_W     8     // data word
`define PAT_INSTR_W    23    // full instruction word
`define PAT_REG_ADR_W  3     // register address
`define PAT_REG_COUNT  8     // general registers
`define PAT_IN_PORTS   3     // input ports, one-hot select
`define PAT_SHAMT_W    2     // shift amount field, encodes 1..4
`define PAT_OP_W       4     // opcode width in every opcode space

// nop with condition always
// rn=0, reserved=0, cond=11, op8=1111, i3 prefix 1111, i0 nop 0101
`define PAT_INSTR_NOP  23'h003ff5

`endif

// File: pat_core.f
+incdir+include
design/pat_isa_pkg.sv
design/pat_pipe_pkg.sv
design/pat_alu.sv
design/pat_regfile.sv
design/pat_decode.sv
design/pat_execute.sv
design/pat_core.sv
bench/pat_core_tb.sv
